//--- include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width
`define CORE_XLEN 32

// architectural register file
`define CORE_REG_NUM 32
`define CORE_REG_AW 5

`define CORE_RESET_PC 32'hbfc00000

// two words per fetch
`define CORE_FETCH_BYTES 8

`define CORE_IBUF_DEPTH 8
`define CORE_WEN_W 4

`endif

//--- rtl/core_pkg.sv
`default_nettype none
`include "core_cfg.svh"

package core_pkg;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDIU,
        OP_ORI,
        OP_LUI
    } opcode_e;

    typedef enum logic [1:0] {
        FS_REQ,
        FS_WAIT,
        FS_HOLD
    } fetch_state_e;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        opcode_e                 op;
        logic [`CORE_REG_AW-1:0] rs;
        logic [`CORE_REG_AW-1:0] rt;
        logic [`CORE_REG_AW-1:0] rd;
        // sign or zero extended, or shifted for LUI
        logic [`CORE_XLEN-1:0]   imm;
        logic                    use_rt;
    } issue_slot_t;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        logic                    wr;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   result;
    } retire_slot_t;

endpackage

`default_nettype wire

//--- rtl/core_ifs.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_cfg.svh"

interface fetch_pair_if;
    logic                  valid;
    logic                  ready;
    logic [`CORE_XLEN-1:0] pc;
    // inst_lo at pc, inst_hi at pc+4
    logic [`CORE_XLEN-1:0] inst_lo;
    logic [`CORE_XLEN-1:0] inst_hi;

    modport producer (output valid, pc, inst_lo, inst_hi, input ready);
    modport consumer (input valid, pc, inst_lo, inst_hi, output ready);
endinterface

interface inst_queue_if;
    // number of words shown, capped at two
    logic [1:0]            count;
    logic [`CORE_XLEN-1:0] head_pc;
    logic [`CORE_XLEN-1:0] head_inst;
    logic [`CORE_XLEN-1:0] next_pc;
    logic [`CORE_XLEN-1:0] next_inst;
    logic [1:0]            pop;

    modport queue (output count, head_pc, head_inst, next_pc, next_inst, input pop);
    modport issue (input count, head_pc, head_inst, next_pc, next_inst, output pop);
endinterface

`default_nettype wire

//--- rtl/inst_fetch.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_cfg.svh"

module inst_fetch (
    input  logic                  clk,
    input  logic                  rst_n_i,
    output logic                  inst_req_o,
    output logic [`CORE_XLEN-1:0] inst_addr_o,
    input  logic                  inst_addr_ok_i,
    input  logic                  inst_data_ok_i,
    input  logic [`CORE_XLEN-1:0] inst1_rdata_i,
    input  logic [`CORE_XLEN-1:0] inst2_rdata_i,
    fetch_pair_if.producer        fetch_o
);
    import core_pkg::*;

    fetch_state_e          state_q;
    logic [`CORE_XLEN-1:0] pc_q;
    logic                  pair_valid_q;
    logic [`CORE_XLEN-1:0] inst_lo_q;
    logic [`CORE_XLEN-1:0] inst_hi_q;

    // reset parks in FS_HOLD with nothing held, so req stays low
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q      <= FS_HOLD;
            pc_q         <= `CORE_RESET_PC;
            pair_valid_q <= 1'b0;
        end else begin
            case (state_q)
                FS_REQ: begin
                    if (inst_addr_ok_i) begin
                        state_q <= FS_WAIT;
                    end
                end
                FS_WAIT: begin
                    if (inst_data_ok_i) begin
                        state_q      <= FS_HOLD;
                        pair_valid_q <= 1'b1;
                    end
                end
                default: begin
                    if (fetch_o.ready || !pair_valid_q) begin
                        state_q      <= FS_REQ;
                        pair_valid_q <= 1'b0;
                        if (pair_valid_q) begin
                            pc_q <= pc_q + `CORE_XLEN'(`CORE_FETCH_BYTES);
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == FS_WAIT && inst_data_ok_i) begin
            inst_lo_q <= inst1_rdata_i;
            inst_hi_q <= inst2_rdata_i;
        end
    end

    assign inst_req_o      = state_q == FS_REQ;
    assign inst_addr_o     = pc_q;
    assign fetch_o.valid   = pair_valid_q;
    assign fetch_o.pc      = pc_q;
    assign fetch_o.inst_lo = inst_lo_q;
    assign fetch_o.inst_hi = inst_hi_q;

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_req_o && !inst_addr_ok_i |=> inst_req_o && $stable(inst_addr_o))
        else $error("fetch address changed while waiting for addr_ok");

endmodule

`default_nettype wire

//--- rtl/inst_buffer.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_cfg.svh"

module inst_buffer (
    input logic            clk,
    input logic            rst_n_i,
    fetch_pair_if.consumer fetch_i,
    inst_queue_if.queue    queue_o
);
    localparam int PTR_W = $clog2(`CORE_IBUF_DEPTH);
    localparam int OCC_W = $clog2(`CORE_IBUF_DEPTH + 1);

    logic [`CORE_XLEN-1:0] inst_mem [`CORE_IBUF_DEPTH];
    logic [`CORE_XLEN-1:0] pc_mem [`CORE_IBUF_DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [PTR_W-1:0]      wr_ptr_inc;
    logic [PTR_W-1:0]      rd_ptr_inc;
    logic [OCC_W-1:0]      occ_q;
    logic                  push;

    assign push       = fetch_i.valid && fetch_i.ready;
    assign wr_ptr_inc = wr_ptr_q + 1'b1;
    assign rd_ptr_inc = rd_ptr_q + 1'b1;

    // room for a whole pair
    assign fetch_i.ready = occ_q <= OCC_W'(`CORE_IBUF_DEPTH - 2);

    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[wr_ptr_q]   <= fetch_i.inst_lo;
            pc_mem[wr_ptr_q]     <= fetch_i.pc;
            inst_mem[wr_ptr_inc] <= fetch_i.inst_hi;
            pc_mem[wr_ptr_inc]   <= fetch_i.pc + `CORE_XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            occ_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(2);
            end
            rd_ptr_q <= rd_ptr_q + PTR_W'(queue_o.pop);
            occ_q    <= occ_q + (push ? OCC_W'(2) : OCC_W'(0)) - OCC_W'(queue_o.pop);
        end
    end

    // the two oldest entries
    assign queue_o.count     = (occ_q >= OCC_W'(2)) ? 2'd2 : occ_q[1:0];
    assign queue_o.head_pc   = pc_mem[rd_ptr_q];
    assign queue_o.head_inst = inst_mem[rd_ptr_q];
    assign queue_o.next_pc   = pc_mem[rd_ptr_inc];
    assign queue_o.next_inst = inst_mem[rd_ptr_inc];

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        occ_q <= OCC_W'(`CORE_IBUF_DEPTH))
        else $error("instruction buffer overflow");

    a_pop_le_count: assert property (@(posedge clk) disable iff (!rst_n_i)
        queue_o.pop <= queue_o.count)
        else $error("issue popped more words than the buffer holds");

endmodule

`default_nettype wire

//--- rtl/dual_issue.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_cfg.svh"

module dual_issue (
    input  logic                 clk,
    input  logic                 rst_n_i,
    inst_queue_if.issue          queue_i,
    output core_pkg::issue_slot_t slot0_o,
    output core_pkg::issue_slot_t slot1_o
);
    import core_pkg::*;

    issue_slot_t dec0;
    issue_slot_t dec1;
    issue_slot_t slot0_q;
    issue_slot_t slot1_q;
    logic        hazard;
    logic        pair;

    function automatic issue_slot_t decode(input logic [`CORE_XLEN-1:0] pc,
                                           input logic [`CORE_XLEN-1:0] inst);
        issue_slot_t d;
        d.valid  = 1'b0;
        d.pc     = pc;
        d.rs     = inst[25:21];
        d.rt     = inst[20:16];
        d.rd     = '0;
        d.imm    = '0;
        d.use_rt = 1'b0;
        case (inst[31:26])
            6'h00: begin
                case (inst[5:0])
                    6'h21:   d.op = OP_ADDU;
                    6'h23:   d.op = OP_SUBU;
                    6'h24:   d.op = OP_AND;
                    6'h25:   d.op = OP_OR;
                    6'h26:   d.op = OP_XOR;
                    6'h2a:   d.op = OP_SLT;
                    default: d.op = OP_NOP;
                endcase
            end
            6'h09:   d.op = OP_ADDIU;
            6'h0d:   d.op = OP_ORI;
            6'h0f:   d.op = OP_LUI;
            default: d.op = OP_NOP;
        endcase
        case (d.op)
            OP_NOP: begin
                d.rs = '0;
                d.rt = '0;
            end
            OP_ADDIU: begin
                d.rd  = inst[20:16];
                d.imm = {{16{inst[15]}}, inst[15:0]};
            end
            OP_ORI: begin
                d.rd  = inst[20:16];
                d.imm = {16'b0, inst[15:0]};
            end
            OP_LUI: begin
                d.rs  = '0;
                d.rd  = inst[20:16];
                d.imm = {inst[15:0], 16'b0};
            end
            // register-register ops
            default: begin
                d.rd     = inst[15:11];
                d.use_rt = 1'b1;
            end
        endcase
        return d;
    endfunction

    assign dec0 = decode(queue_i.head_pc, queue_i.head_inst);
    assign dec1 = decode(queue_i.next_pc, queue_i.next_inst);

    // second word reads what the first one writes
    assign hazard = (dec0.rd != '0)
        && (dec1.rs == dec0.rd || (dec1.use_rt && dec1.rt == dec0.rd));
    assign pair = (queue_i.count == 2'd2) && !hazard;

    assign queue_i.pop = (queue_i.count == 2'd0) ? 2'd0 : (pair ? 2'd2 : 2'd1);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            slot0_q.valid <= 1'b0;
            slot1_q.valid <= 1'b0;
        end else begin
            slot0_q       <= dec0;
            slot0_q.valid <= queue_i.count != 2'd0;
            slot1_q       <= dec1;
            slot1_q.valid <= pair;
        end
    end

    assign slot0_o = slot0_q;
    assign slot1_o = slot1_q;

    a_pair_indep: assert property (@(posedge clk) disable iff (!rst_n_i)
        slot1_q.valid |-> slot0_q.valid && !(slot0_q.rd != '0
        && (slot1_q.rs == slot0_q.rd || (slot1_q.use_rt && slot1_q.rt == slot0_q.rd))))
        else $error("dependent pair issued together");

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_cfg.svh"

module exec_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  core_pkg::issue_slot_t   slot0_i,
    input  core_pkg::issue_slot_t   slot1_i,
    output logic [`CORE_REG_AW-1:0] rs0_addr_o,
    output logic [`CORE_REG_AW-1:0] rt0_addr_o,
    output logic [`CORE_REG_AW-1:0] rs1_addr_o,
    output logic [`CORE_REG_AW-1:0] rt1_addr_o,
    input  logic [`CORE_XLEN-1:0]   rs0_data_i,
    input  logic [`CORE_XLEN-1:0]   rt0_data_i,
    input  logic [`CORE_XLEN-1:0]   rs1_data_i,
    input  logic [`CORE_XLEN-1:0]   rt1_data_i,
    output core_pkg::retire_slot_t  retire0_o,
    output core_pkg::retire_slot_t  retire1_o
);
    import core_pkg::*;

    retire_slot_t          retire0_q;
    retire_slot_t          retire1_q;
    logic [`CORE_XLEN-1:0] res0;
    logic [`CORE_XLEN-1:0] res1;

    // previous group still sits in the retire register; slot1 is younger
    function automatic logic [`CORE_XLEN-1:0] fwd(input logic [`CORE_REG_AW-1:0] idx,
                                                   input logic [`CORE_XLEN-1:0] rf_data);
        logic [`CORE_XLEN-1:0] v;
        v = rf_data;
        if (retire0_q.valid && retire0_q.wr && retire0_q.rd == idx) begin
            v = retire0_q.result;
        end
        if (retire1_q.valid && retire1_q.wr && retire1_q.rd == idx) begin
            v = retire1_q.result;
        end
        return v;
    endfunction

    function automatic logic [`CORE_XLEN-1:0] alu(input issue_slot_t s,
                                                   input logic [`CORE_XLEN-1:0] a,
                                                   input logic [`CORE_XLEN-1:0] b);
        case (s.op)
            OP_ADDU:  return a + b;
            OP_SUBU:  return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLT:   return {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_ADDIU: return a + s.imm;
            OP_ORI:   return a | s.imm;
            OP_LUI:   return s.imm;
            default:  return '0;
        endcase
    endfunction

    function automatic retire_slot_t to_retire(input issue_slot_t s,
                                               input logic [`CORE_XLEN-1:0] res);
        retire_slot_t r;
        r.valid  = s.valid;
        r.pc     = s.pc;
        r.wr     = s.valid && s.op != OP_NOP && s.rd != '0;
        r.rd     = s.rd;
        r.result = res;
        return r;
    endfunction

    assign rs0_addr_o = slot0_i.rs;
    assign rt0_addr_o = slot0_i.rt;
    assign rs1_addr_o = slot1_i.rs;
    assign rt1_addr_o = slot1_i.rt;

    assign res0 = alu(slot0_i, fwd(slot0_i.rs, rs0_data_i), fwd(slot0_i.rt, rt0_data_i));
    assign res1 = alu(slot1_i, fwd(slot1_i.rs, rs1_data_i), fwd(slot1_i.rt, rt1_data_i));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire0_q.valid <= 1'b0;
            retire0_q.wr    <= 1'b0;
            retire1_q.valid <= 1'b0;
            retire1_q.wr    <= 1'b0;
        end else begin
            retire0_q <= to_retire(slot0_i, res0);
            retire1_q <= to_retire(slot1_i, res1);
        end
    end

    assign retire0_o = retire0_q;
    assign retire1_o = retire1_q;

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_cfg.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [`CORE_REG_AW-1:0] rs0_addr_i,
    input  logic [`CORE_REG_AW-1:0] rt0_addr_i,
    input  logic [`CORE_REG_AW-1:0] rs1_addr_i,
    input  logic [`CORE_REG_AW-1:0] rt1_addr_i,
    output logic [`CORE_XLEN-1:0]   rs0_data_o,
    output logic [`CORE_XLEN-1:0]   rt0_data_o,
    output logic [`CORE_XLEN-1:0]   rs1_data_o,
    output logic [`CORE_XLEN-1:0]   rt1_data_o,
    input  core_pkg::retire_slot_t  retire0_i,
    input  core_pkg::retire_slot_t  retire1_i
);
    logic [`CORE_XLEN-1:0] regs_q [`CORE_REG_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (retire0_i.valid && retire0_i.wr) begin
                regs_q[retire0_i.rd] <= retire0_i.result;
            end
            // later write, younger slot wins on the same index
            if (retire1_i.valid && retire1_i.wr) begin
                regs_q[retire1_i.rd] <= retire1_i.result;
            end
        end
    end

    assign rs0_data_o = (rs0_addr_i == '0) ? '0 : regs_q[rs0_addr_i];
    assign rt0_data_o = (rt0_addr_i == '0) ? '0 : regs_q[rt0_addr_i];
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rt1_data_o = (rt1_addr_i == '0) ? '0 : regs_q[rt1_addr_i];

endmodule

`default_nettype wire

//--- rtl/cpu_core.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_cfg.svh"

module cpu_core (
    input  logic                    clk,
    input  logic                    rst_n_i,
    output logic                    inst_req_o,
    output logic [`CORE_XLEN-1:0]   inst_addr_o,
    input  logic [`CORE_XLEN-1:0]   inst1_rdata_i,
    input  logic [`CORE_XLEN-1:0]   inst2_rdata_i,
    input  logic                    inst_addr_ok_i,
    input  logic                    inst_data_ok_i,
    output logic [`CORE_XLEN-1:0]   debug_wb_pc_1_o,
    output logic [`CORE_WEN_W-1:0]  debug_wb_rf_wen_1_o,
    output logic [`CORE_REG_AW-1:0] debug_wb_rf_wnum_1_o,
    output logic [`CORE_XLEN-1:0]   debug_wb_rf_wdata_1_o,
    output logic [`CORE_XLEN-1:0]   debug_wb_pc_2_o,
    output logic [`CORE_WEN_W-1:0]  debug_wb_rf_wen_2_o,
    output logic [`CORE_REG_AW-1:0] debug_wb_rf_wnum_2_o,
    output logic [`CORE_XLEN-1:0]   debug_wb_rf_wdata_2_o
);
    import core_pkg::*;

    issue_slot_t             slot0;
    issue_slot_t             slot1;
    retire_slot_t            retire0;
    retire_slot_t            retire1;
    logic [`CORE_REG_AW-1:0] rs0_addr;
    logic [`CORE_REG_AW-1:0] rt0_addr;
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rt1_addr;
    logic [`CORE_XLEN-1:0]   rs0_data;
    logic [`CORE_XLEN-1:0]   rt0_data;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rt1_data;

    fetch_pair_if fetch_bus ();
    inst_queue_if queue_bus ();

    inst_fetch u_fetch (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_req_o     (inst_req_o),
        .inst_addr_o    (inst_addr_o),
        .inst_addr_ok_i (inst_addr_ok_i),
        .inst_data_ok_i (inst_data_ok_i),
        .inst1_rdata_i  (inst1_rdata_i),
        .inst2_rdata_i  (inst2_rdata_i),
        .fetch_o        (fetch_bus.producer)
    );

    inst_buffer u_buffer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .fetch_i (fetch_bus.consumer),
        .queue_o (queue_bus.queue)
    );

    dual_issue u_issue (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .queue_i (queue_bus.issue),
        .slot0_o (slot0),
        .slot1_o (slot1)
    );

    exec_unit u_exec (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .slot0_i    (slot0),
        .slot1_i    (slot1),
        .rs0_addr_o (rs0_addr),
        .rt0_addr_o (rt0_addr),
        .rs1_addr_o (rs1_addr),
        .rt1_addr_o (rt1_addr),
        .rs0_data_i (rs0_data),
        .rt0_data_i (rt0_data),
        .rs1_data_i (rs1_data),
        .rt1_data_i (rt1_data),
        .retire0_o  (retire0),
        .retire1_o  (retire1)
    );

    reg_file u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs0_addr_i (rs0_addr),
        .rt0_addr_i (rt0_addr),
        .rs1_addr_i (rs1_addr),
        .rt1_addr_i (rt1_addr),
        .rs0_data_o (rs0_data),
        .rt0_data_o (rt0_data),
        .rs1_data_o (rs1_data),
        .rt1_data_o (rt1_data),
        .retire0_i  (retire0),
        .retire1_i  (retire1)
    );

    // channel 1 is the older slot of the group
    assign debug_wb_pc_1_o       = retire0.pc;
    assign debug_wb_rf_wen_1_o   = {`CORE_WEN_W{retire0.valid && retire0.wr}};
    assign debug_wb_rf_wnum_1_o  = retire0.rd;
    assign debug_wb_rf_wdata_1_o = retire0.result;
    assign debug_wb_pc_2_o       = retire1.pc;
    assign debug_wb_rf_wen_2_o   = {`CORE_WEN_W{retire1.valid && retire1.wr}};
    assign debug_wb_rf_wnum_2_o  = retire1.rd;
    assign debug_wb_rf_wdata_2_o = retire1.result;

endmodule

`default_nettype wire

//--- dv/tb_inst_mem.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_cfg.svh"

module tb_inst_mem #(
    parameter int PROG_LEN = 320
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  inst_req_i,
    input  logic [`CORE_XLEN-1:0] inst_addr_i,
    output logic                  inst_addr_ok_o,
    output logic                  inst_data_ok_o,
    output logic [`CORE_XLEN-1:0] inst1_rdata_o,
    output logic [`CORE_XLEN-1:0] inst2_rdata_o
);
    localparam logic [1:0] P_IDLE = 2'd0;
    localparam logic [1:0] P_ACK  = 2'd1;
    localparam logic [1:0] P_DATA = 2'd2;

    logic [`CORE_XLEN-1:0] prog [PROG_LEN];
    logic                  addr_ok_q = 1'b0;
    logic                  data_ok_q = 1'b0;
    logic [`CORE_XLEN-1:0] rdata1_q = '0;
    logic [`CORE_XLEN-1:0] rdata2_q = '0;
    logic [`CORE_XLEN-1:0] addr_q;
    logic [1:0]            phase_q;
    int unsigned           delay_q;
    int unsigned           req_cnt_q;

    function automatic logic [`CORE_XLEN-1:0] random_inst();
        logic [4:0]            rs;
        logic [4:0]            rt;
        logic [4:0]            rd;
        logic [15:0]           imm;
        logic [`CORE_XLEN-1:0] w;
        // only r0..r7, so neighbours often depend on each other
        rs  = 5'($urandom % 8);
        rt  = 5'($urandom % 8);
        rd  = 5'($urandom % 8);
        imm = 16'($urandom);
        case ($urandom % 12)
            0:       w = {6'h00, rs, rt, rd, 5'd0, 6'h21};
            1:       w = {6'h00, rs, rt, rd, 5'd0, 6'h23};
            2:       w = {6'h00, rs, rt, rd, 5'd0, 6'h24};
            3:       w = {6'h00, rs, rt, rd, 5'd0, 6'h25};
            4:       w = {6'h00, rs, rt, rd, 5'd0, 6'h26};
            5:       w = {6'h00, rs, rt, rd, 5'd0, 6'h2a};
            6:       w = {6'h09, rs, rt, imm};
            7:       w = {6'h0d, rs, rt, imm};
            8:       w = {6'h0f, 5'd0, rt, imm};
            // mult and lw, not supported
            9:       w = {6'h00, rs, rt, 5'd0, 5'd0, 6'h18};
            10:      w = {6'h23, rs, rt, imm};
            default: w = {6'h00, rs, rt, rd, 5'd0, 6'h21};
        endcase
        return w;
    endfunction

    // bursts of immediate replies, then slow windows
    function automatic int unsigned pick_delay(input int unsigned n);
        int unsigned d;
        case (n[5:4])
            2'd1:    d = 0;
            2'd3:    d = 5;
            default: d = $urandom % 6;
        endcase
        return d;
    endfunction

    function automatic logic [`CORE_XLEN-1:0] word_at(input logic [`CORE_XLEN-1:0] addr);
        int idx;
        idx = int'((addr - `CORE_RESET_PC) >> 2);
        if (idx >= 0 && idx < PROG_LEN) begin
            return prog[idx];
        end
        return '0;
    endfunction

    initial begin
        void'($urandom(32'hef5b05ad));
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = random_inst();
        end
    end

    always @(posedge clk) begin
        addr_ok_q <= 1'b0;
        data_ok_q <= 1'b0;
        if (!rst_n_i) begin
            phase_q   <= P_IDLE;
            delay_q   <= 0;
            req_cnt_q <= 0;
        end else begin
            case (phase_q)
                P_IDLE: begin
                    if (inst_req_i) begin
                        if (delay_q == 0) begin
                            addr_ok_q <= 1'b1;
                            addr_q    <= inst_addr_i;
                            phase_q   <= P_ACK;
                        end else begin
                            delay_q <= delay_q - 1;
                        end
                    end
                end
                // request is taken on this edge
                P_ACK: begin
                    delay_q <= pick_delay(req_cnt_q);
                    phase_q <= P_DATA;
                end
                default: begin
                    if (delay_q == 0) begin
                        data_ok_q <= 1'b1;
                        rdata1_q  <= word_at(addr_q);
                        rdata2_q  <= word_at(addr_q + 4);
                        req_cnt_q <= req_cnt_q + 1;
                        delay_q   <= pick_delay(req_cnt_q);
                        phase_q   <= P_IDLE;
                    end else begin
                        delay_q <= delay_q - 1;
                    end
                end
            endcase
        end
    end

    assign inst_addr_ok_o = addr_ok_q;
    assign inst_data_ok_o = data_ok_q;
    assign inst1_rdata_o  = rdata1_q;
    assign inst2_rdata_o  = rdata2_q;

endmodule

`default_nettype wire

//--- dv/tb_cpu_core.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_cfg.svh"

module tb_cpu_core;
    localparam int PROG_LEN       = 320;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int DRAIN_CYCLES   = 16;

    logic                    clk;
    logic                    rst_n;
    logic                    inst_req;
    logic [`CORE_XLEN-1:0]   inst_addr;
    logic [`CORE_XLEN-1:0]   inst1_rdata;
    logic [`CORE_XLEN-1:0]   inst2_rdata;
    logic                    inst_addr_ok;
    logic                    inst_data_ok;
    logic [`CORE_XLEN-1:0]   wb_pc_1;
    logic [`CORE_WEN_W-1:0]  wb_wen_1;
    logic [`CORE_REG_AW-1:0] wb_num_1;
    logic [`CORE_XLEN-1:0]   wb_data_1;
    logic [`CORE_XLEN-1:0]   wb_pc_2;
    logic [`CORE_WEN_W-1:0]  wb_wen_2;
    logic [`CORE_REG_AW-1:0] wb_num_2;
    logic [`CORE_XLEN-1:0]   wb_data_2;

    // expected register writes in program order
    logic [`CORE_XLEN-1:0]   exp_pc [$];
    logic [`CORE_REG_AW-1:0] exp_num [$];
    logic [`CORE_XLEN-1:0]   exp_val [$];
    logic [`CORE_XLEN-1:0]   exp_src [$];
    logic [`CORE_XLEN-1:0]   exp_addr;
    logic                    outstanding;

    cpu_core dut (
        .clk                   (clk),
        .rst_n_i               (rst_n),
        .inst_req_o            (inst_req),
        .inst_addr_o           (inst_addr),
        .inst1_rdata_i         (inst1_rdata),
        .inst2_rdata_i         (inst2_rdata),
        .inst_addr_ok_i        (inst_addr_ok),
        .inst_data_ok_i        (inst_data_ok),
        .debug_wb_pc_1_o       (wb_pc_1),
        .debug_wb_rf_wen_1_o   (wb_wen_1),
        .debug_wb_rf_wnum_1_o  (wb_num_1),
        .debug_wb_rf_wdata_1_o (wb_data_1),
        .debug_wb_pc_2_o       (wb_pc_2),
        .debug_wb_rf_wen_2_o   (wb_wen_2),
        .debug_wb_rf_wnum_2_o  (wb_num_2),
        .debug_wb_rf_wdata_2_o (wb_data_2)
    );

    tb_inst_mem #(.PROG_LEN(PROG_LEN)) u_mem (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .inst_req_i     (inst_req),
        .inst_addr_i    (inst_addr),
        .inst_addr_ok_o (inst_addr_ok),
        .inst_data_ok_o (inst_data_ok),
        .inst1_rdata_o  (inst1_rdata),
        .inst2_rdata_o  (inst2_rdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic fail_check(input string name, input logic [`CORE_XLEN-1:0] expected,
                              input logic [`CORE_XLEN-1:0] actual);
        $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        stop_run();
    endtask

    task automatic fail_plain(input string what);
        $display("error: %s", what);
        stop_run();
    endtask

    // in-order reference run of the program that drops r0 writes and no-ops
    task automatic build_golden();
        logic [`CORE_XLEN-1:0]   regs [`CORE_REG_NUM];
        logic [`CORE_XLEN-1:0]   w;
        logic [`CORE_XLEN-1:0]   a;
        logic [`CORE_XLEN-1:0]   b;
        logic [`CORE_XLEN-1:0]   res;
        logic [`CORE_XLEN-1:0]   src;
        logic [`CORE_REG_AW-1:0] dst;
        logic                    wr;
        for (int i = 0; i < `CORE_REG_NUM; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w   = u_mem.prog[i];
            a   = regs[w[25:21]];
            b   = regs[w[20:16]];
            dst = w[15:11];
            wr  = 1'b1;
            res = '0;
            src = (32'd1 << w[25:21]) | (32'd1 << w[20:16]);
            case (w[31:26])
                6'h00: begin
                    case (w[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: begin
                    dst = w[20:16];
                    src = 32'd1 << w[25:21];
                    res = a + {{16{w[15]}}, w[15:0]};
                end
                6'h0d: begin
                    dst = w[20:16];
                    src = 32'd1 << w[25:21];
                    res = a | {16'h0000, w[15:0]};
                end
                6'h0f: begin
                    dst = w[20:16];
                    src = '0;
                    res = {w[15:0], 16'h0000};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = res;
                exp_pc.push_back(`CORE_RESET_PC + 32'(4 * i));
                exp_num.push_back(dst);
                exp_val.push_back(res);
                exp_src.push_back(src);
            end
        end
    endtask

    // older_dst is channel 1's destination when checking channel 2 and r0 otherwise
    task automatic check_write(input string chan, input logic [`CORE_WEN_W-1:0] wen,
                               input logic [`CORE_XLEN-1:0] pc,
                               input logic [`CORE_REG_AW-1:0] num,
                               input logic [`CORE_XLEN-1:0] data,
                               input logic [`CORE_REG_AW-1:0] older_dst);
        logic [`CORE_XLEN-1:0] src;
        if (exp_pc.size() == 0) begin
            fail_plain($sformatf("%s reported a write at pc %h past the program", chan, pc));
        end else begin
            src = exp_src[0];
            assert (wen == {`CORE_WEN_W{1'b1}})
                else fail_check({chan, " wen"}, 32'({`CORE_WEN_W{1'b1}}), 32'(wen));
            assert (pc == exp_pc[0]) else fail_check({chan, " pc"}, exp_pc[0], pc);
            assert (num == exp_num[0])
                else fail_check({chan, " wnum"}, 32'(exp_num[0]), 32'(num));
            assert (data == exp_val[0]) else fail_check({chan, " wdata"}, exp_val[0], data);
            assert (older_dst == '0 || !src[older_dst])
                else fail_plain($sformatf("pairing: pc %h reads r%0d written by its partner",
                                          pc, older_dst));
            void'(exp_pc.pop_front());
            void'(exp_num.pop_front());
            void'(exp_val.pop_front());
            void'(exp_src.pop_front());
        end
    endtask

    // values seen at the falling edge are the ones the next rising edge samples
    task automatic check_cycle();
        if (inst_data_ok) begin
            outstanding = 1'b0;
        end
        if (inst_req) begin
            assert (!outstanding)
                else fail_plain("fetch: new request raised while another is outstanding");
        end
        if (inst_req && inst_addr_ok) begin
            assert (inst_addr == exp_addr) else fail_check("fetch addr", exp_addr, inst_addr);
            exp_addr    = exp_addr + `CORE_FETCH_BYTES;
            outstanding = 1'b1;
        end
        if (wb_wen_1 != '0) begin
            check_write("results ch1", wb_wen_1, wb_pc_1, wb_num_1, wb_data_1, '0);
        end
        if (wb_wen_2 != '0) begin
            check_write("results ch2", wb_wen_2, wb_pc_2, wb_num_2, wb_data_2,
                        (wb_wen_1 != '0) ? wb_num_1 : '0);
        end
    endtask

    a_fetch_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr))
        else fail_plain("fetch: request dropped or address moved before addr_ok");

    initial begin
        int wait_cycles;
        rst_n       = 1'b0;
        exp_addr    = `CORE_RESET_PC;
        outstanding = 1'b0;
        wait_cycles = 0;
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            assert (!inst_req && wb_wen_1 == '0 && wb_wen_2 == '0)
                else fail_plain("reset: fetch request or write-enable active in reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        build_golden();

        while (exp_pc.size() != 0 && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            check_cycle();
            wait_cycles++;
        end
        // a duplicate or stray write would still show up here
        for (int i = 0; i < DRAIN_CYCLES && exp_pc.size() == 0; i++) begin
            @(negedge clk);
            check_cycle();
        end

        if (exp_pc.size() != 0) begin
            $display("error: timeout with %0d expected writes not reported", exp_pc.size());
            stop_run();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
rtl/core_pkg.sv
rtl/core_ifs.sv
rtl/inst_fetch.sv
rtl/inst_buffer.sv
rtl/dual_issue.sv
rtl/exec_unit.sv
rtl/reg_file.sv
rtl/cpu_core.sv
dv/tb_inst_mem.sv
dv/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# compile the core and its testbench with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_cpu_core \
    -f flist.f \
    -Mdir obj_dir \
    -o sim_cpu_core

./obj_dir/sim_cpu_core
